/* Bender.yml */
package:
  name: videoSubsystem

sources:
  - design/memBusPkg.sv
  - design/videoPkg.sv
  - design/resetSequencer.sv
  - design/busArbiter.sv
  - design/cameraWriter.sv
  - design/displayReader.sv
  - design/frameMemory.sv
  - design/videoSubsystem.sv
  - target: test
    files:
      - verif/videoSubsystemTb.sv

/* design/busArbiter.sv */
`timescale 1ns/1ps

module busArbiter
  import memBusPkg::*;
(
  input  logic        s_systemClock,
  input  logic        systemReset,
  input  memRequest_t displayRequest,
  input  logic        displayWants,
  input  memRequest_t cameraRequest,
  input  logic        cameraWants,
  output logic        displayGrant,
  output logic        cameraGrant,
  output memRequest_t memoryRequest,
  output logic        memoryEnable,
  input  memWord_t    memoryReadData,
  output memWord_t    replyData,
  output logic        displayReply
);

  logic [NUM_REQUESTERS-1:0] requestVector;
  logic [NUM_REQUESTERS-1:0] grantVector;
  logic                      displayReadPending;

  always_comb begin
    requestVector              = '0;
    requestVector[REQ_DISPLAY] = displayWants;
    requestVector[REQ_CAMERA]  = cameraWants;
  end

  // Keep only the lowest set request bit
  assign grantVector = requestVector & (~requestVector + NUM_REQUESTERS'(1));

  assign displayGrant = grantVector[REQ_DISPLAY];
  assign cameraGrant  = grantVector[REQ_CAMERA];

  assign memoryEnable  = |requestVector;
  assign memoryRequest = displayGrant ? displayRequest : cameraRequest;

  // The memory answers one cycle after the access, so remember who asked
  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      displayReadPending <= 1'b0;
    end else begin
      displayReadPending <= displayGrant & ~displayRequest.write;
    end
  end

  assign displayReply = displayReadPending;
  assign replyData    = memoryReadData;

endmodule

/* design/cameraWriter.sv */
`timescale 1ns/1ps

module cameraWriter
  import memBusPkg::*;
  import videoPkg::*;
(
  input  logic        s_systemClock,
  input  logic        systemReset,
  input  pixelBeat_t  pixelIn,
  input  logic        pixelValid,
  output logic        pixelReady,
  output memRequest_t busRequest,
  output logic        busWants,
  input  logic        busGrant
);

  logic        haveLowHalf;
  logic        wordPending;
  logic        pixelTransfer;
  memAddress_t writeAddress;
  rgb565_t     lowHalf;
  memWord_t    pendingWord;

  // No pixel is taken while a packed word still waits for the bus
  assign pixelReady    = ~wordPending & ~systemReset;
  assign pixelTransfer = pixelValid & pixelReady;

  assign busWants   = wordPending;
  assign busRequest = '{address: writeAddress, writeData: pendingWord, write: 1'b1};

  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      haveLowHalf  <= 1'b0;
      wordPending  <= 1'b0;
      writeAddress <= '0;
    end else begin
      if (pixelTransfer) begin
        if (pixelIn.startOfFrame) begin
          writeAddress <= '0;
          haveLowHalf  <= 1'b1;
        end else if (haveLowHalf) begin
          haveLowHalf <= 1'b0;
          wordPending <= 1'b1;
        end else begin
          haveLowHalf <= 1'b1;
        end
      end
      if (busGrant) begin
        wordPending  <= 1'b0;
        writeAddress <= writeAddress + 1'b1;
      end
    end
  end

  // First pixel of a pair lands in the low half of the word
  always_ff @(posedge s_systemClock) begin
    if (pixelTransfer) begin
      if (pixelIn.startOfFrame || !haveLowHalf) begin
        lowHalf <= pixelIn.pixel;
      end else begin
        pendingWord <= {pixelIn.pixel, lowHalf};
      end
    end
  end

endmodule

/* design/displayReader.sv */
`timescale 1ns/1ps

module displayReader
  import memBusPkg::*;
  import videoPkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic         s_systemClock,
  input  logic         systemReset,
  input  readCommand_t command,
  input  logic         commandValid,
  output logic         commandReady,
  output memRequest_t  busRequest,
  output logic         busWants,
  input  logic         busGrant,
  input  memWord_t     replyData,
  input  logic         displayReply,
  output memWord_t     readData,
  output logic         readValid,
  input  logic         readReady
);

  localparam int POINTER_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int COUNT_WIDTH   = $clog2(FIFO_DEPTH + 1);

  typedef enum logic [1:0] {readerIdle, readerFetch, readerDrain} readerState_t;

  readerState_t             readerState;
  memAddress_t              fetchAddress;
  runLength_t               wordsLeft;
  memWord_t                 fifoMemory [FIFO_DEPTH];
  logic [POINTER_WIDTH-1:0] writePointer;
  logic [POINTER_WIDTH-1:0] readPointer;
  logic [COUNT_WIDTH-1:0]   fifoCount;
  logic [COUNT_WIDTH-1:0]   freeSpace;
  logic                     pushWord;
  logic                     popWord;

  function automatic logic [POINTER_WIDTH-1:0] nextPointer(
    input logic [POINTER_WIDTH-1:0] pointer
  );
    return (pointer == POINTER_WIDTH'(FIFO_DEPTH - 1)) ? '0 : pointer + 1'b1;
  endfunction

  assign commandReady = (readerState == readerIdle) & ~systemReset;

  // A reply arriving now still needs a slot, so it counts against the credit
  assign freeSpace = COUNT_WIDTH'(FIFO_DEPTH) - fifoCount;
  assign busWants  = (readerState == readerFetch) && (wordsLeft != '0) &&
                     (freeSpace > COUNT_WIDTH'(displayReply));
  assign busRequest = '{address: fetchAddress, writeData: '0, write: 1'b0};

  assign pushWord  = displayReply;
  assign popWord   = readValid & readReady;
  assign readValid = (fifoCount != '0);
  assign readData  = fifoMemory[readPointer];

  // ====================
  // Command FSM
  // ====================

  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      readerState  <= readerIdle;
      fetchAddress <= '0;
      wordsLeft    <= '0;
    end else begin
      case (readerState)
        readerIdle: begin
          if (commandValid && commandReady) begin
            fetchAddress <= command.startAddress;
            wordsLeft    <= command.wordCount;
            readerState  <= readerFetch;
          end
        end
        readerFetch: begin
          if (wordsLeft == '0) begin
            readerState <= readerDrain;
          end else if (busGrant) begin
            fetchAddress <= fetchAddress + 1'b1;
            wordsLeft    <= wordsLeft - 1'b1;
            if (wordsLeft == runLength_t'(1)) begin
              readerState <= readerDrain;
            end
          end
        end
        readerDrain: begin
          // Last reply may still be on its way from memory
          if (fifoCount == '0 && !displayReply) begin
            readerState <= readerIdle;
          end
        end
        default: readerState <= readerIdle;
      endcase
    end
  end

  // ====================
  // Reply FIFO
  // ====================

  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      writePointer <= '0;
      readPointer  <= '0;
      fifoCount    <= '0;
    end else begin
      if (pushWord) begin
        writePointer <= nextPointer(writePointer);
      end
      if (popWord) begin
        readPointer <= nextPointer(readPointer);
      end
      case ({pushWord, popWord})
        2'b10:   fifoCount <= fifoCount + 1'b1;
        2'b01:   fifoCount <= fifoCount - 1'b1;
        default: fifoCount <= fifoCount;
      endcase
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (pushWord) begin
      fifoMemory[writePointer] <= replyData;
    end
  end

endmodule

/* design/frameMemory.sv */
`timescale 1ns/1ps

module frameMemory
  import memBusPkg::*;
(
  input  logic        s_systemClock,
  input  memRequest_t memoryRequest,
  input  logic        memoryEnable,
  output memWord_t    memoryReadData
);

  localparam int MEMORY_WORDS = 2 ** $bits(memAddress_t);

  memWord_t memoryArray [MEMORY_WORDS];
  memWord_t readRegister;

  // Single port, a read word appears one cycle after its access
  always_ff @(posedge s_systemClock) begin
    if (memoryEnable) begin
      if (memoryRequest.write) begin
        memoryArray[memoryRequest.address] <= memoryRequest.writeData;
      end else begin
        readRegister <= memoryArray[memoryRequest.address];
      end
    end
  end

  assign memoryReadData = readRegister;

endmodule

/* design/memBusPkg.sv */
package memBusPkg;

  // ====================
  // Bus widths
  // ====================

  // Word address into the frame memory
  typedef logic [9:0] memAddress_t;

  typedef logic [31:0] memWord_t;

  // One access on the shared memory bus, a read when write is low
  typedef struct packed {
    memAddress_t address;
    memWord_t    writeData;
    logic        write;
  } memRequest_t;

  // ====================
  // Requesters
  // ====================

  localparam int NUM_REQUESTERS = 2;

  // The lower index has the higher priority
  localparam int REQ_DISPLAY = 0;
  localparam int REQ_CAMERA  = 1;

endpackage

/* design/resetSequencer.sv */
`timescale 1ns/1ps

module resetSequencer #(
  parameter int RESET_CYCLES = 16
) (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic systemReset,
  output logic cameraResetN
);

  localparam int COUNT_WIDTH = $clog2(RESET_CYCLES + 1);

  logic [COUNT_WIDTH-1:0] lockCount;
  logic                   resetDone;

  // Loss of lock throws the whole system back into reset at once
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      lockCount <= '0;
      resetDone <= 1'b0;
    end else if (!resetDone) begin
      if (lockCount == COUNT_WIDTH'(RESET_CYCLES - 1)) begin
        resetDone <= 1'b1;
      end else begin
        lockCount <= lockCount + 1'b1;
      end
    end
  end

  assign systemReset  = ~resetDone;
  assign cameraResetN = resetDone;

endmodule

/* design/videoPkg.sv */
package videoPkg;

  import memBusPkg::memAddress_t;

  typedef logic [15:0] rgb565_t;

  // Number of words in one read run, zero means an empty run
  typedef logic [7:0] runLength_t;

  // One camera pixel with its frame marker
  typedef struct packed {
    rgb565_t pixel;
    logic    startOfFrame;
  } pixelBeat_t;

  typedef struct packed {
    memAddress_t startAddress;
    runLength_t  wordCount;
  } readCommand_t;

endpackage

/* design/videoSubsystem.sv */
`timescale 1ns/1ps

module videoSubsystem
  import memBusPkg::*;
  import videoPkg::*;
#(
  parameter int RESET_CYCLES = 16,
  parameter int FIFO_DEPTH   = 4
) (
  input  logic         s_systemClock,
  input  logic         s_pllLocked,
  input  pixelBeat_t   pixelIn,
  input  logic         pixelValid,
  output logic         pixelReady,
  input  readCommand_t command,
  input  logic         commandValid,
  output logic         commandReady,
  output memWord_t     readData,
  output logic         readValid,
  input  logic         readReady,
  output logic         cameraResetN
);

  logic        systemReset;
  memRequest_t displayRequest;
  memRequest_t cameraRequest;
  memRequest_t memoryRequest;
  logic        displayWants;
  logic        cameraWants;
  logic        displayGrant;
  logic        cameraGrant;
  logic        memoryEnable;
  logic        displayReply;
  memWord_t    memoryReadData;
  memWord_t    replyData;

  resetSequencer #(.RESET_CYCLES(RESET_CYCLES)) u_resetSequencer (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .systemReset  (systemReset),
    .cameraResetN (cameraResetN)
  );

  // ====================
  // Bus peers
  // ====================

  cameraWriter u_cameraWriter (
    .s_systemClock(s_systemClock),
    .systemReset  (systemReset),
    .pixelIn      (pixelIn),
    .pixelValid   (pixelValid),
    .pixelReady   (pixelReady),
    .busRequest   (cameraRequest),
    .busWants     (cameraWants),
    .busGrant     (cameraGrant)
  );

  displayReader #(.FIFO_DEPTH(FIFO_DEPTH)) u_displayReader (
    .s_systemClock(s_systemClock),
    .systemReset  (systemReset),
    .command      (command),
    .commandValid (commandValid),
    .commandReady (commandReady),
    .busRequest   (displayRequest),
    .busWants     (displayWants),
    .busGrant     (displayGrant),
    .replyData    (replyData),
    .displayReply (displayReply),
    .readData     (readData),
    .readValid    (readValid),
    .readReady    (readReady)
  );

  // ====================
  // Shared memory
  // ====================

  busArbiter u_busArbiter (
    .s_systemClock (s_systemClock),
    .systemReset   (systemReset),
    .displayRequest(displayRequest),
    .displayWants  (displayWants),
    .cameraRequest (cameraRequest),
    .cameraWants   (cameraWants),
    .displayGrant  (displayGrant),
    .cameraGrant   (cameraGrant),
    .memoryRequest (memoryRequest),
    .memoryEnable  (memoryEnable),
    .memoryReadData(memoryReadData),
    .replyData     (replyData),
    .displayReply  (displayReply)
  );

  frameMemory u_frameMemory (
    .s_systemClock (s_systemClock),
    .memoryRequest (memoryRequest),
    .memoryEnable  (memoryEnable),
    .memoryReadData(memoryReadData)
  );

endmodule

/* files.f */
design/memBusPkg.sv
design/videoPkg.sv
design/resetSequencer.sv
design/busArbiter.sv
design/cameraWriter.sv
design/displayReader.sv
design/frameMemory.sv
design/videoSubsystem.sv
verif/videoSubsystemTb.sv

/* verif/videoSubsystemTb.sv */
`timescale 1ns/1ps

module videoSubsystemTb
  import memBusPkg::*;
  import videoPkg::*;
;

  localparam int RESET_CYCLES = 16;
  localparam int FIFO_DEPTH   = 2;

  logic         s_systemClock;
  logic         s_pllLocked;
  pixelBeat_t   pixelIn;
  logic         pixelValid;
  logic         pixelReady;
  readCommand_t command;
  logic         commandValid;
  logic         commandReady;
  memWord_t     readData;
  logic         readValid;
  logic         readReady;
  logic         cameraResetN;

  int          checkCount;
  int          errorCount;
  int          timeoutCount;
  int          timeoutLimit;
  logic [31:0] randomState;
  memWord_t    expectedWords [$];
  memWord_t    expectedWord;
  string       testLines [$];

  videoSubsystem #(.RESET_CYCLES(RESET_CYCLES), .FIFO_DEPTH(FIFO_DEPTH)) u_dut (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .pixelIn      (pixelIn),
    .pixelValid   (pixelValid),
    .pixelReady   (pixelReady),
    .command      (command),
    .commandValid (commandValid),
    .commandReady (commandReady),
    .readData     (readData),
    .readValid    (readValid),
    .readReady    (readReady),
    .cameraResetN (cameraResetN)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #10 s_systemClock = ~s_systemClock;
  end

  function automatic logic [31:0] nextRandom(input logic [31:0] state);
    logic [31:0] value;
    value = state;
    value = value ^ (value << 13);
    value = value ^ (value >> 17);
    value = value ^ (value << 5);
    return value;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic finishRun();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  // ====================
  // Drivers
  // ====================

  // Ready only moves on a rising edge, so seen high here the beat goes on the next one
  task automatic sendPixel(input logic startOfFrame, input rgb565_t pixel);
    @(negedge s_systemClock);
    commandValid = 1'b0;
    pixelIn      = '{pixel: pixel, startOfFrame: startOfFrame};
    pixelValid   = 1'b1;
    while (!pixelReady) @(negedge s_systemClock);
    @(posedge s_systemClock);
  endtask

  task automatic sendCommand(input memAddress_t startAddress, input runLength_t wordCount);
    @(negedge s_systemClock);
    pixelValid   = 1'b0;
    command      = '{startAddress: startAddress, wordCount: wordCount};
    commandValid = 1'b1;
    while (!commandReady) @(negedge s_systemClock);
    @(posedge s_systemClock);
    @(negedge s_systemClock);
    commandValid = 1'b0;
  endtask

  // Stall readReady about one cycle in four
  // Every word leaving the DUT must match the oldest expected word
  always @(negedge s_systemClock) begin
    randomState = nextRandom(randomState);
    readReady   = (randomState[1:0] != 2'b00);
    if (readValid && readReady) begin
      if (expectedWords.size() == 0) begin
        errorCount++;
        $display("A read word %h came out at %0t ns with no expected word left", readData, $time);
      end else begin
        expectedWord = expectedWords.pop_front();
        checkValue("readData", readData, expectedWord);
      end
    end
  end

  initial begin
    int cyclesRun;
    cyclesRun = 0;
    wait (timeoutLimit != 0);
    while (cyclesRun < timeoutLimit) begin
      @(posedge s_systemClock);
      cyclesRun++;
    end
    timeoutCount++;
    $display("Timeout: the tests did not finish within %0d cycles", timeoutLimit);
    finishRun();
  end

  // ====================
  // Test sequence
  // ====================

  initial begin
    int          fileHandle;
    string       lineText;
    logic [7:0]  kind;
    logic [31:0] fieldA;
    logic [31:0] fieldB;
    int          fieldCount;
    s_pllLocked  = 1'b0;
    pixelIn      = '0;
    pixelValid   = 1'b0;
    command      = '0;
    commandValid = 1'b0;
    readReady    = 1'b0;
    randomState  = 32'd13;
    checkCount   = 0;
    errorCount   = 0;
    timeoutCount = 0;
    timeoutLimit = 0;
    fileHandle = $fopen("verif/videoTests.txt", "r");
    if (fileHandle == 0) begin
      errorCount++;
      $display("The test file verif/videoTests.txt could not be opened");
    end else begin
      while (!$feof(fileHandle)) begin
        if ($fgets(lineText, fileHandle) != 0) begin
          testLines.push_back(lineText);
        end
      end
      $fclose(fileHandle);
    end
    timeoutLimit = 40 * testLines.size() + 200;

    repeat (10) @(negedge s_systemClock);
    checkValue("cameraResetN", cameraResetN, 1'b0);
    s_pllLocked = 1'b1;
    // All three outputs release together on the last counted edge
    for (int edgeIndex = 1; edgeIndex <= RESET_CYCLES; edgeIndex++) begin
      @(negedge s_systemClock);
      checkValue("cameraResetN", cameraResetN, edgeIndex == RESET_CYCLES);
      checkValue("commandReady", commandReady, edgeIndex == RESET_CYCLES);
      checkValue("pixelReady", pixelReady, edgeIndex == RESET_CYCLES);
    end

    foreach (testLines[lineIndex]) begin
      lineText = testLines[lineIndex];
      if (lineText.len() < 2 || lineText[0] == "#") begin
        continue;
      end
      fieldCount = $sscanf(lineText, "%c %h %h", kind, fieldA, fieldB);
      case (kind)
        "P": sendPixel(fieldA[0], rgb565_t'(fieldB));
        "C": sendCommand(memAddress_t'(fieldA), runLength_t'(fieldB));
        "E": expectedWords.push_back(memWord_t'(fieldA));
        default: begin
          errorCount++;
          $display("Test line %0d has an unknown kind (%0d fields read)", lineIndex + 1,
                   fieldCount);
        end
      endcase
    end

    @(negedge s_systemClock);
    pixelValid   = 1'b0;
    commandValid = 1'b0;
    while (expectedWords.size() != 0) @(posedge s_systemClock);
    @(negedge s_systemClock);
    while (!commandReady) @(negedge s_systemClock);
    finishRun();
  end

endmodule

/* verif/videoTests.txt */
# P startOfFrame pixel | C startAddress wordCount | E expectedWord
# All numbers are hex, E lines follow the C line whose replies they describe
P 1 1111
P 0 2222
P 0 3333
P 0 4444
P 0 5555
P 0 6666
C 000 03
E 22221111
E 44443333
E 66665555
C 001 02
E 44443333
E 66665555
P 1 aaaa
P 0 bbbb
C 000 03
E bbbbaaaa
E 44443333
E 66665555
C 000 00
